/* cnn.f */
cnn_pkg.sv
line_window.sv
conv_engine.sv
pool_stage.sv
dense_classifier.sv
cnn_top.sv
cnn_clkgen.sv
cnn_chk.sv
cnn_tb.sv

/* run_sim.sh */
#!/bin/sh
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module cnn_tb -f cnn.f > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vcnn_tb > sim.log 2>&1 || true
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1
exit 0

/* cnn_tb.sv */
`default_nettype none

module cnn_tb import cnn_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int ROW_W = IMG_W * PIX_W;
	localparam int RESET_CYCLES = 16;
	localparam int N_TESTS = 11;
	localparam int WATCHDOG_CYCLES = N_TESTS * 40 + RESET_CYCLES;
	localparam int LATENCY = 6;

	// image sources
	localparam int K_ZERO = 0;
	localparam int K_RAND = 1;
	localparam int K_BRIGHT = 2;
	localparam int K_RAMP = 3;
	localparam int K_TIE = 4;
	localparam int K_PREV = 5;
	localparam int GAP_NONE = 0;
	localparam int GAP_RAND = 1;

	typedef struct packed {
		int kind;
		int gap;
		int exp_class;
	} test_t;

	// exp_class of -1 leaves the class to the model alone
	test_t tests [N_TESTS] = '{
		'{K_ZERO, GAP_NONE, 2},
		'{K_RAND, GAP_NONE, -1},
		'{K_RAND, GAP_NONE, -1},
		'{K_RAND, GAP_NONE, -1},
		'{K_BRIGHT, GAP_NONE, -1},
		'{K_RAMP, GAP_NONE, -1},
		'{K_RAND, GAP_RAND, -1},
		'{K_PREV, GAP_RAND, -1},
		'{K_RAND, GAP_RAND, -1},
		'{K_TIE, GAP_RAND, 1},
		'{K_ZERO, GAP_RAND, 2}
	};

	logic clk;
	logic resetn;
	logic [ROW_W-1:0] row_i;
	logic row_valid_i;
	logic row_ready_o;
	logic [CLASS_W-1:0] class_o;
	logic [N_CLASS*ACC_W-1:0] scores_o;
	logic class_valid_o;

	logic [31:0] rng_state;
	logic [ROW_W-1:0] cur_img [IMG_H];
	int cycle_cnt = 0;
	int n_checked = 0;
	logic [N_CLASS*ACC_W-1:0] exp_scores_q [$];
	int exp_class_q [$];
	int tab_class_q [$];
	int accept_cycle_q [$];
	int test_id_q [$];

	cnn_clkgen u_clkgen (
		.clk_o(clk)
	);

	cnn_top #(
		.IMG_H(IMG_H),
		.IMG_W(IMG_W)
	) UUT (
		.clk(clk),
		.resetn(resetn),
		.row_i(row_i),
		.row_valid_i(row_valid_i),
		.row_ready_o(row_ready_o),
		.class_o(class_o),
		.scores_o(scores_o),
		.class_valid_o(class_valid_o)
	);

	bind cnn_top cnn_chk #(
		.IMG_H(IMG_H)
	) u_cnn_chk (
		.clk(clk),
		.resetn(resetn),
		.row_valid_i(row_valid_i),
		.row_ready_i(row_ready_o),
		.class_valid_i(class_valid_o)
	);

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	// xorshift32
	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic void build_image(input int kind);
		for (int r = 0; r < IMG_H; r++) begin
			case (kind)
				K_ZERO, K_TIE: cur_img[r] = '0;
				K_RAND: begin
					cur_img[r][31:0] = next_rand();
					cur_img[r][63:32] = next_rand();
				end
				K_BRIGHT: cur_img[r] = '1;
				K_RAMP: begin
					// falls left to right, so the edge filter goes negative
					for (int c = 0; c < IMG_W; c++) begin
						cur_img[r][c*PIX_W +: PIX_W] = PIX_W'(255 - 32 * c);
					end
				end
				default: ;
			endcase
		end
		// one pixel in the top right corner, makes classes 1 and 2 tie at 146
		if (kind == K_TIE) begin
			cur_img[0][ROW_W-1 -: PIX_W] = 8'hE3;
		end
	endfunction

	function automatic int pixel_at(input int r, input int c);
		if (r < 0 || r >= IMG_H || c < 0 || c >= IMG_W) begin
			return 0;
		end
		return int'(cur_img[r][c*PIX_W +: PIX_W]);
	endfunction

	// reference conv, relu, pool and dense on cur_img
	function automatic void model_image(output logic [N_CLASS*ACC_W-1:0] scores,
			output int cls);
		int feat [IMG_H][IMG_W][N_FILT];
		int score [N_CLASS];
		int sum;
		int pmax;
		int idx;
		for (int r = 0; r < IMG_H; r++) begin
			for (int c = 0; c < IMG_W; c++) begin
				for (int f = 0; f < N_FILT; f++) begin
					sum = int'(conv_bias[f]);
					for (int i = 0; i < 3; i++) begin
						for (int j = 0; j < 3; j++) begin
							sum += pixel_at(r + i - 1, c + j - 1) * int'(conv_weight[f][i][j]);
						end
					end
					sum = sum >>> CONV_SHIFT;
					feat[r][c][f] = (sum < 0) ? 0 : (sum > 255) ? 255 : sum;
				end
			end
		end
		for (int k = 0; k < N_CLASS; k++) begin
			score[k] = int'(dense_bias[k]);
		end
		for (int pr = 0; pr < IMG_H / 2; pr++) begin
			for (int pc = 0; pc < IMG_W / 2; pc++) begin
				for (int f = 0; f < N_FILT; f++) begin
					pmax = 0;
					for (int dr = 0; dr < 2; dr++) begin
						for (int dc = 0; dc < 2; dc++) begin
							if (feat[2*pr+dr][2*pc+dc][f] > pmax) begin
								pmax = feat[2*pr+dr][2*pc+dc][f];
							end
						end
					end
					idx = (pr * (IMG_W / 2) + pc) * N_FILT + f;
					for (int k = 0; k < N_CLASS; k++) begin
						score[k] += pmax * int'($signed(dense_weight[k][idx*WGT_W +: WGT_W]));
					end
				end
			end
		end
		cls = 0;
		for (int k = 1; k < N_CLASS; k++) begin
			if (score[k] > score[cls]) begin
				cls = k;
			end
		end
		for (int k = 0; k < N_CLASS; k++) begin
			scores[k*ACC_W +: ACC_W] = ACC_W'(score[k]);
		end
	endfunction

	task automatic send_image(input int id, input int gap_mode,
			input logic [N_CLASS*ACC_W-1:0] scores, input int cls, input int tab_cls);
		int gaps;
		for (int r = 0; r < IMG_H; r++) begin
			gaps = (gap_mode == GAP_RAND) ? int'(next_rand() % 4) : 0;
			if (gaps > 0) begin
				row_valid_i = 1'b0;
				repeat (gaps) begin
					@(posedge clk);
					#1;
				end
			end
			row_i = cur_img[r];
			row_valid_i = 1'b1;
			@(posedge clk);
			while (!row_ready_o) begin
				@(posedge clk);
			end
			if (r == IMG_H - 1) begin
				exp_scores_q.push_back(scores);
				exp_class_q.push_back(cls);
				tab_class_q.push_back(tab_cls);
				accept_cycle_q.push_back(cycle_cnt);
				test_id_q.push_back(id);
			end
			#1;
		end
	endtask

	// result monitor
	always @(posedge clk) begin
		logic [N_CLASS*ACC_W-1:0] exp_s;
		int exp_c;
		int tab_c;
		int acc_c;
		int id;
		cycle_cnt <= cycle_cnt + 1;
		if (resetn === 1'b1 && class_valid_o === 1'b1) begin
			assert (exp_scores_q.size() > 0)
				else abort_run("class_valid_o pulsed while no image was outstanding");
			exp_s = exp_scores_q.pop_front();
			exp_c = exp_class_q.pop_front();
			tab_c = tab_class_q.pop_front();
			acc_c = accept_cycle_q.pop_front();
			id = test_id_q.pop_front();
			assert (scores_o === exp_s)
				else abort_run($sformatf("** Error: scores_o = 0x%h, expected 0x%h (test %0d)",
					scores_o, exp_s, id));
			assert (class_o === CLASS_W'(exp_c))
				else abort_run($sformatf("** Error: class_o = 0x%h, expected 0x%h (test %0d)",
					class_o, exp_c, id));
			if (tab_c >= 0) begin
				assert (class_o === CLASS_W'(tab_c))
					else abort_run($sformatf("** Error: class_o = 0x%h, table 0x%h (test %0d)",
						class_o, tab_c, id));
			end
			assert (cycle_cnt - acc_c == LATENCY)
				else abort_run($sformatf("** Error: class_valid_o latency = 0x%h, expected 0x%h",
					cycle_cnt - acc_c, LATENCY));
			n_checked <= n_checked + 1;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		abort_run("Timeout: the DUT did not deliver all results in time");
	end

	initial begin
		logic [N_CLASS*ACC_W-1:0] scores;
		int cls;
		rng_state = 32'h1a1c6843;
		resetn = 1'b0;
		row_i = '0;
		row_valid_i = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		resetn = 1'b1;
		@(posedge clk);
		assert (row_ready_o === 1'b1)
			else abort_run($sformatf("** Error: row_ready_o = 0x%h after reset, expected 0x1",
				row_ready_o));
		assert (class_valid_o === 1'b0)
			else abort_run($sformatf("** Error: class_valid_o = 0x%h after reset, expected 0x0",
				class_valid_o));
		#1;
		for (int n = 0; n < N_TESTS; n++) begin
			build_image(tests[n].kind);
			model_image(scores, cls);
			send_image(n, tests[n].gap, scores, cls, tests[n].exp_class);
		end
		row_valid_i = 1'b0;
		wait (n_checked == N_TESTS);
		// idle tail so that a stray pulse still reaches the monitor
		repeat (8) @(posedge clk);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* cnn_chk.sv */
`default_nettype none

module cnn_chk import cnn_pkg::*; #(
	parameter int IMG_H = cnn_pkg::IMG_H
) (
	input wire clk,
	input wire resetn,
	input wire row_valid_i,
	input wire row_ready_i,
	input wire class_valid_i
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CNT_W = $clog2(IMG_H);

	logic [CNT_W-1:0] row_cnt;
	logic last_acc;

	// high on the edge that takes the last row of an image
	assign last_acc = row_valid_i && row_ready_i && (row_cnt == CNT_W'(IMG_H - 1));

	always_ff @(posedge clk) begin
		if (!resetn) begin
			row_cnt <= '0;
		end else if (row_valid_i && row_ready_i) begin
			row_cnt <= (row_cnt == CNT_W'(IMG_H - 1)) ? '0 : row_cnt + 1'b1;
		end
	end

	a_single_pulse: assert property (@(posedge clk) disable iff (!resetn)
		class_valid_i |=> !class_valid_i)
		else $error("class_valid_o stayed high for two cycles");

	// ready drops only in the flush cycle
	a_ready_gap: assert property (@(posedge clk) disable iff (!resetn)
		row_ready_i == !$past(last_acc))
		else $error("row_ready_o low outside the cycle after the last row");

	a_latency: assert property (@(posedge clk) disable iff (!resetn)
		class_valid_i == $past(last_acc, 6))
		else $error("class_valid_o not 6 cycles after the last row");

endmodule

`default_nettype wire

/* cnn_clkgen.sv */
`default_nettype none

module cnn_clkgen (
	output logic clk_o
);
	timeunit 1ns;
	timeprecision 100ps;

	// 8 ns period
	initial begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o;
	end

endmodule

`default_nettype wire

/* cnn_top.sv */
`default_nettype none

module cnn_top import cnn_pkg::*; #(
	parameter int IMG_H = cnn_pkg::IMG_H,
	parameter int IMG_W = cnn_pkg::IMG_W
) (
	input wire clk,
	input wire resetn,
	input wire [IMG_W*PIX_W-1:0] row_i,
	input wire row_valid_i,
	output logic row_ready_o,
	output logic [CLASS_W-1:0] class_o,
	output logic [N_CLASS*ACC_W-1:0] scores_o,
	output logic class_valid_o
);

	logic [IMG_W*PIX_W-1:0] win_top;
	logic [IMG_W*PIX_W-1:0] win_mid;
	logic [IMG_W*PIX_W-1:0] win_bot;
	logic win_valid;
	logic [IMG_W*N_FILT*PIX_W-1:0] feat_row;
	logic feat_valid;
	logic [IMG_W/2*N_FILT*PIX_W-1:0] pool_row;
	logic pool_valid;

	// window formation
	line_window #(
		.IMG_H(IMG_H),
		.IMG_W(IMG_W)
	) u_line_window (
		.clk(clk),
		.resetn(resetn),
		.row_i(row_i),
		.row_valid_i(row_valid_i),
		.row_ready_o(row_ready_o),
		.win_top_o(win_top),
		.win_mid_o(win_mid),
		.win_bot_o(win_bot),
		.win_valid_o(win_valid)
	);

	conv_engine #(
		.IMG_W(IMG_W)
	) u_conv_engine (
		.clk(clk),
		.resetn(resetn),
		.win_top_i(win_top),
		.win_mid_i(win_mid),
		.win_bot_i(win_bot),
		.win_valid_i(win_valid),
		.feat_row_o(feat_row),
		.feat_valid_o(feat_valid)
	);

	pool_stage #(
		.IMG_H(IMG_H),
		.IMG_W(IMG_W)
	) u_pool_stage (
		.clk(clk),
		.resetn(resetn),
		.feat_row_i(feat_row),
		.feat_valid_i(feat_valid),
		.pool_row_o(pool_row),
		.pool_valid_o(pool_valid)
	);

	// class decision
	dense_classifier #(
		.IMG_H(IMG_H)
	) u_dense_classifier (
		.clk(clk),
		.resetn(resetn),
		.pool_row_i(pool_row),
		.pool_valid_i(pool_valid),
		.class_o(class_o),
		.scores_o(scores_o),
		.class_valid_o(class_valid_o)
	);

endmodule

`default_nettype wire

/* dense_classifier.sv */
`default_nettype none

module dense_classifier import cnn_pkg::*; #(
	parameter int IMG_H = cnn_pkg::IMG_H
) (
	input wire clk,
	input wire resetn,
	input wire [N_FEAT/(IMG_H/2)*PIX_W-1:0] pool_row_i,
	input wire pool_valid_i,
	output logic [CLASS_W-1:0] class_o,
	output logic [N_CLASS*ACC_W-1:0] scores_o,
	output logic class_valid_o
);

	localparam int N_PROW = IMG_H / 2;
	localparam int ROW_FEAT = N_FEAT / N_PROW;
	localparam int CNT_W = $clog2(N_PROW);

	logic [CNT_W-1:0] prow_cnt;
	logic last_q;
	logic last_prow;
	logic signed [ACC_W-1:0] acc [N_CLASS];
	logic signed [ACC_W-1:0] base [N_CLASS];
	logic signed [ACC_W-1:0] contrib [N_CLASS];
	logic [CLASS_W-1:0] best_idx;

	assign last_prow = (prow_cnt == CNT_W'(N_PROW - 1));

	// weighted sum of this pooled row, weights picked by row number
	always_comb begin
		logic [PIX_W-1:0] feat;
		logic signed [WGT_W-1:0] wgt;
		feat = '0;
		wgt = '0;
		for (int k = 0; k < N_CLASS; k++) begin
			contrib[k] = '0;
			for (int j = 0; j < ROW_FEAT; j++) begin
				feat = pool_row_i[j * PIX_W +: PIX_W];
				wgt = dense_w(k, int'(prow_cnt) * ROW_FEAT + j);
				contrib[k] = contrib[k] + ACC_W'($signed({1'b0, feat})) * ACC_W'(wgt);
			end
			// a new image may follow right behind the finished one
			base[k] = last_q ? ACC_W'(dense_bias[k]) : acc[k];
		end
	end

	// strict compare keeps the lowest index on a tie
	always_comb begin
		logic signed [ACC_W-1:0] best_val;
		best_val = acc[0];
		best_idx = '0;
		for (int k = 1; k < N_CLASS; k++) begin
			if (acc[k] > best_val) begin
				best_val = acc[k];
				best_idx = CLASS_W'(k);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			prow_cnt <= '0;
			last_q <= 1'b0;
			class_valid_o <= 1'b0;
			for (int k = 0; k < N_CLASS; k++) begin
				acc[k] <= ACC_W'(dense_bias[k]);
			end
		end else begin
			last_q <= pool_valid_i && last_prow;
			class_valid_o <= last_q;
			if (pool_valid_i) begin
				prow_cnt <= last_prow ? '0 : prow_cnt + 1'b1;
			end
			for (int k = 0; k < N_CLASS; k++) begin
				if (pool_valid_i) begin
					acc[k] <= base[k] + contrib[k];
				end else if (last_q) begin
					acc[k] <= ACC_W'(dense_bias[k]);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (last_q) begin
			class_o <= best_idx;
			for (int k = 0; k < N_CLASS; k++) begin
				scores_o[k * ACC_W +: ACC_W] <= acc[k];
			end
		end
	end

endmodule

`default_nettype wire

/* pool_stage.sv */
`default_nettype none

module pool_stage import cnn_pkg::*; #(
	parameter int IMG_H = cnn_pkg::IMG_H,
	parameter int IMG_W = cnn_pkg::IMG_W
) (
	input wire clk,
	input wire resetn,
	input wire [IMG_W*N_FILT*PIX_W-1:0] feat_row_i,
	input wire feat_valid_i,
	output logic [IMG_W/2*N_FILT*PIX_W-1:0] pool_row_o,
	output logic pool_valid_o
);

	localparam int CNT_W = $clog2(IMG_H);
	localparam int ROW_W = IMG_W * N_FILT * PIX_W;

	logic [CNT_W-1:0] row_cnt;
	logic odd_row;
	logic [ROW_W-1:0] even_row;
	logic [IMG_W/2*N_FILT*PIX_W-1:0] pool_d;

	assign odd_row = row_cnt[0];

	function automatic logic [PIX_W-1:0] feat_at(input logic [ROW_W-1:0] row, input int col,
			input int f);
		return row[(col * N_FILT + f) * PIX_W +: PIX_W];
	endfunction

	function automatic logic [PIX_W-1:0] max2(input logic [PIX_W-1:0] a,
			input logic [PIX_W-1:0] b);
		return (a > b) ? a : b;
	endfunction

	// 2x2 block max, stored even row against the arriving odd row
	always_comb begin
		logic [PIX_W-1:0] m_even;
		logic [PIX_W-1:0] m_odd;
		m_even = '0;
		m_odd = '0;
		pool_d = '0;
		for (int c = 0; c < IMG_W / 2; c++) begin
			for (int f = 0; f < N_FILT; f++) begin
				m_even = max2(feat_at(even_row, 2 * c, f), feat_at(even_row, 2 * c + 1, f));
				m_odd = max2(feat_at(feat_row_i, 2 * c, f), feat_at(feat_row_i, 2 * c + 1, f));
				pool_d[(c * N_FILT + f) * PIX_W +: PIX_W] = max2(m_even, m_odd);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			row_cnt <= '0;
			pool_valid_o <= 1'b0;
		end else begin
			pool_valid_o <= feat_valid_i && odd_row;
			if (feat_valid_i) begin
				row_cnt <= (row_cnt == CNT_W'(IMG_H - 1)) ? '0 : row_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (feat_valid_i && !odd_row) begin
			even_row <= feat_row_i;
		end
		if (feat_valid_i && odd_row) begin
			pool_row_o <= pool_d;
		end
	end

endmodule

`default_nettype wire

/* conv_engine.sv */
`default_nettype none

module conv_engine import cnn_pkg::*; #(
	parameter int IMG_W = cnn_pkg::IMG_W
) (
	input wire clk,
	input wire resetn,
	input wire [IMG_W*PIX_W-1:0] win_top_i,
	input wire [IMG_W*PIX_W-1:0] win_mid_i,
	input wire [IMG_W*PIX_W-1:0] win_bot_i,
	input wire win_valid_i,
	output logic [IMG_W*N_FILT*PIX_W-1:0] feat_row_o,
	output logic feat_valid_o
);

	localparam int PAD_W = (IMG_W + 2) * PIX_W;
	localparam logic signed [CONV_W-1:0] SAT_MAX = CONV_W'(2 ** PIX_W - 1);

	logic [PAD_W-1:0] pad [3];
	logic [IMG_W*N_FILT*PIX_W-1:0] feat_d;

	// one zero pixel on each side, padded column 0 is image column -1
	assign pad[0] = {{PIX_W{1'b0}}, win_top_i, {PIX_W{1'b0}}};
	assign pad[1] = {{PIX_W{1'b0}}, win_mid_i, {PIX_W{1'b0}}};
	assign pad[2] = {{PIX_W{1'b0}}, win_bot_i, {PIX_W{1'b0}}};

	// all columns and filters of the row in parallel
	always_comb begin
		logic signed [CONV_W-1:0] sum;
		logic signed [CONV_W-1:0] scaled;
		logic [PIX_W-1:0] pix;
		sum = '0;
		scaled = '0;
		pix = '0;
		feat_d = '0;
		for (int c = 0; c < IMG_W; c++) begin
			for (int f = 0; f < N_FILT; f++) begin
				sum = CONV_W'(conv_bias[f]);
				for (int i = 0; i < 3; i++) begin
					for (int j = 0; j < 3; j++) begin
						pix = pad[i][(c + j) * PIX_W +: PIX_W];
						sum = sum + CONV_W'($signed({1'b0, pix})) *
							CONV_W'(conv_weight[f][i][j]);
					end
				end
				scaled = sum >>> CONV_SHIFT;
				// relu, then clamp to the pixel range
				if (scaled < 0) begin
					feat_d[(c * N_FILT + f) * PIX_W +: PIX_W] = '0;
				end else if (scaled > SAT_MAX) begin
					feat_d[(c * N_FILT + f) * PIX_W +: PIX_W] = '1;
				end else begin
					feat_d[(c * N_FILT + f) * PIX_W +: PIX_W] = scaled[PIX_W-1:0];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			feat_valid_o <= 1'b0;
		end else begin
			feat_valid_o <= win_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (win_valid_i) begin
			feat_row_o <= feat_d;
		end
	end

endmodule

`default_nettype wire

/* line_window.sv */
`default_nettype none

module line_window import cnn_pkg::*; #(
	parameter int IMG_H = cnn_pkg::IMG_H,
	parameter int IMG_W = cnn_pkg::IMG_W
) (
	input wire clk,
	input wire resetn,
	input wire [IMG_W*PIX_W-1:0] row_i,
	input wire row_valid_i,
	output logic row_ready_o,
	output logic [IMG_W*PIX_W-1:0] win_top_o,
	output logic [IMG_W*PIX_W-1:0] win_mid_o,
	output logic [IMG_W*PIX_W-1:0] win_bot_o,
	output logic win_valid_o
);

	localparam int CNT_W = $clog2(IMG_H);
	localparam int ROW_W = IMG_W * PIX_W;

	logic [CNT_W-1:0] row_cnt;
	logic flush_q;
	logic accept;
	logic last_row;
	// prev1 is the most recent row, prev2 the one before it
	logic [ROW_W-1:0] prev1;
	logic [ROW_W-1:0] prev2;

	// one bubble after the last row to push out the bottom window
	assign row_ready_o = !flush_q;
	assign accept = row_valid_i && row_ready_o;
	assign last_row = (row_cnt == CNT_W'(IMG_H - 1));

	always_ff @(posedge clk) begin
		if (!resetn) begin
			row_cnt <= '0;
			flush_q <= 1'b0;
			win_valid_o <= 1'b0;
		end else begin
			flush_q <= accept && last_row;
			// first row of an image only fills the buffer
			win_valid_o <= (accept && (row_cnt != '0)) || flush_q;
			if (accept) begin
				row_cnt <= last_row ? '0 : row_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			prev2 <= prev1;
			prev1 <= row_i;
			// window centred on the previous row, zero above row 0
			win_top_o <= (row_cnt == CNT_W'(1)) ? '0 : prev2;
			win_mid_o <= prev1;
			win_bot_o <= row_i;
		end else if (flush_q) begin
			// bottom edge, nothing below the last row
			win_top_o <= prev2;
			win_mid_o <= prev1;
			win_bot_o <= '0;
		end
	end

endmodule

`default_nettype wire

/* cnn_pkg.sv */
`default_nettype none

package cnn_pkg;

	// image geometry
	localparam int PIX_W = 8;
	localparam int IMG_H = 8;
	localparam int IMG_W = 8;
	localparam int N_FILT = 2;
	localparam int N_CLASS = 4;
	localparam int CLASS_W = $clog2(N_CLASS);
	// pooled features per image, ordered row, column, filter
	localparam int N_FEAT = (IMG_H / 2) * (IMG_W / 2) * N_FILT;

	// arithmetic widths
	localparam int WGT_W = 4;
	localparam int CONV_W = 16;
	localparam int CONV_SHIFT = 3;
	localparam int ACC_W = 18;

	// indexed [filter][kernel row][kernel col], kernel row 0 sits on the upper image row
	localparam logic signed [WGT_W-1:0] conv_weight [N_FILT][3][3] = '{
		'{'{-4'sd1, 4'sd0, 4'sd1}, '{-4'sd2, 4'sd0, 4'sd2}, '{-4'sd1, 4'sd0, 4'sd1}},
		'{'{4'sd1, 4'sd1, 4'sd1}, '{4'sd1, 4'sd2, 4'sd1}, '{4'sd1, 4'sd1, 4'sd1}}
	};

	// small enough that a flat zero image shifts down to zero features
	localparam logic signed [7:0] conv_bias [N_FILT] = '{8'sd5, -8'sd6};

	// one nibble per feature, feature 0 in the low nibble
	localparam logic [N_FEAT*WGT_W-1:0] dense_weight [N_CLASS] = '{
		128'h21F0_3E12_0F31_D201_12E0_F132_01D3_2F10,
		128'hE213_0F2D_1230_E1F2_3D01_2F1E_0321_F0E2,
		128'h0123_F2E1_D032_1F0E_2301_E1F2_10D3_2E0F,
		128'h3F01_2E10_F23D_0121_E0F3_1D20_2F01_E132
	};

	localparam logic signed [11:0] dense_bias [N_CLASS] = '{
		12'sd40, -12'sd25, 12'sd90, 12'sd10
	};

	// signed dense weight for one class and one flat feature index
	function automatic logic signed [WGT_W-1:0] dense_w(input int cls, input int feat);
		return $signed(dense_weight[cls][feat*WGT_W +: WGT_W]);
	endfunction

endpackage

`default_nettype wire
